/* rtl/readout_pkg.sv */
// ==============================
// Shared widths, output word layout and readout FSM states.
// Imported by the readout buffer interfaces and modules.
// ==============================

package readout_pkg;

    localparam int data_width      = 32;  // Hit and output word width.
    localparam int size_width      = 16;  // FIFO size and word counts.
    localparam int frame_num_width = 12;

    localparam logic [3:0] header_marker = 4'hA;

    // Header view of an output word.
    typedef struct packed {
        logic [3:0]                 marker;
        logic [frame_num_width-1:0] frame_num;
        logic [size_width-1:0]      count;
    } header_view_t;

    // One output word, read either as a header or as raw hit data.
    typedef union packed {
        header_view_t          header;
        logic [data_width-1:0] raw;
    } frame_word_t;

    typedef enum logic [1:0] {
        idle   = 2'd0,
        header = 2'd1,
        data   = 2'd2
    } readout_state_t;

endpackage

/* rtl/fifo_if.sv */
// ==============================
// Bundles between the readout blocks.
// fifo_if wraps the FIFO ports, frame_ctrl_if the frame controls.
// ==============================
`timescale 1ns/10ps

interface fifo_if import readout_pkg::*; ();
    logic                  write;
    logic                  read;
    logic [data_width-1:0] data_in;
    logic [data_width-1:0] data_out;  // Head of queue while not empty.
    logic                  full;
    logic                  empty;
    logic [size_width-1:0] size;

    modport fifo (input write, read, data_in, output data_out, full, empty, size);
    modport consumer (output read, input empty, size);
    modport source (input data_out, write, full);  // Write and full feed overflow.
endinterface

interface frame_ctrl_if import readout_pkg::*; ();
    logic                  load_header;
    logic                  pass_data;
    logic [size_width-1:0] word_count;  // Data words in the current frame.
    logic                  frame_done;

    modport fsm (output load_header, pass_data, word_count, frame_done);
    modport builder (input load_header, pass_data, word_count, frame_done);
    modport timer (input pass_data, frame_done, word_count);
endinterface

/* rtl/generic_fifo.sv */
// ==============================
// Circular buffer FIFO with wrapping pointers.
// Registered empty and head word, full and size from the pointers.
// One slot stays unused, so it holds DEPTH-1 words.
// ==============================
`timescale 1ns/10ps

module generic_fifo import readout_pkg::*; #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
) (
    input logic   clk,
    input logic   reset,
    fifo_if.fifo  bus
);

    localparam int ptr_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [ptr_width-1:0] last_ptr = ptr_width'(DEPTH - 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ptr_width-1:0]  rd_ptr;
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_inc;
    logic [ptr_width-1:0]  wr_inc;
    logic [ptr_width-1:0]  rd_next;
    logic                  do_read;
    logic                  do_write;
    logic                  empty_reg;

    assign do_read  = bus.read && !empty_reg;  // Reads on empty are ignored.
    assign do_write = bus.write && !bus.full;  // Writes on full are dropped.

    assign rd_inc  = (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
    assign wr_inc  = (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
    assign rd_next = do_read ? rd_inc : rd_ptr;  // Head after this edge.

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (do_read)
                rd_ptr <= rd_inc;
            if (do_write)
                wr_ptr <= wr_inc;
        end
    end

    // A read that takes the last word empties at once.
    // A write clears empty one edge later.
    always_ff @(posedge clk) begin
        if (reset)
            empty_reg <= 1'b1;
        else if (do_read)
            empty_reg <= (wr_ptr == rd_inc);
        else
            empty_reg <= (wr_ptr == rd_ptr);
    end

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= bus.data_in;
        bus.data_out <= mem[rd_next];  // Prefetch of the next head word.
    end

    assign bus.empty = empty_reg;
    assign bus.full  = (wr_inc == rd_ptr);

    always_comb begin
        if (wr_ptr >= rd_ptr)
            bus.size = size_width'(wr_ptr) - size_width'(rd_ptr);
        else
            bus.size = size_width'(DEPTH) - size_width'(rd_ptr) + size_width'(wr_ptr);
    end

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (bus.write && bus.full && !do_read) |=> (bus.size == $past(bus.size))
    ) else $error("FIFO accepted a write while full");

    // An overrun would wrap size from the bound back to zero.
    a_size_bound: assert property (
        @(posedge clk) disable iff (reset)
        (bus.size == size_width'(DEPTH - 1)) |=> (bus.size >= size_width'(DEPTH - 2))
    ) else $error("FIFO size %0d wrapped past DEPTH-1", bus.size);

endmodule

/* rtl/frame_timer.sv */
// ==============================
// Idle timer for frame flushing and data word counter.
// flush_due asks the FSM to send a short frame.
// ==============================
`timescale 1ns/10ps

module frame_timer import readout_pkg::*; #(
    parameter int FLUSH_CYCLES = 8,
    parameter int FRAME_WORDS  = 4
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         write_seen,
    input  logic         fifo_empty,
    frame_ctrl_if.timer  ctrl,
    output logic         flush_due,
    output logic         last_word
);

    localparam int idle_width  = $clog2(FLUSH_CYCLES + 1);
    localparam int count_width = $clog2(FRAME_WORDS + 1);

    logic [idle_width-1:0]  idle_cnt;
    logic [count_width-1:0] word_cnt;
    logic                   idle_limit;

    assign idle_limit = (idle_cnt == idle_width'(FLUSH_CYCLES));

    // Cycles since the last write, saturating.
    always_ff @(posedge clk) begin
        if (reset)
            idle_cnt <= '0;
        else if (write_seen)
            idle_cnt <= '0;  // Any write restarts the wait.
        else if (!idle_limit)
            idle_cnt <= idle_cnt + 1'b1;
    end

    assign flush_due = idle_limit && !fifo_empty;  // Only when data is waiting.

    always_ff @(posedge clk) begin
        if (reset)
            word_cnt <= '0;
        else if (ctrl.frame_done)
            word_cnt <= '0;
        else if (ctrl.pass_data)
            word_cnt <= word_cnt + 1'b1;
    end

    // Final data cycle of the frame.
    assign last_word = ctrl.pass_data &&
                       (size_width'(word_cnt) == ctrl.word_count - 1'b1);

endmodule

/* rtl/readout_fsm.sv */
// ==============================
// Readout FSM, decides when a frame starts and sequences it.
// One header cycle, then one FIFO read per data word.
// ==============================
`timescale 1ns/10ps

module readout_fsm import readout_pkg::*; #(
    parameter int FRAME_WORDS = 4
) (
    input  logic       clk,
    input  logic       reset,
    fifo_if.consumer   fifo,
    frame_ctrl_if.fsm  ctrl,
    input  logic       flush_due,
    input  logic       last_word
);

    localparam logic [size_width-1:0] frame_limit = size_width'(FRAME_WORDS);

    readout_state_t        state;
    readout_state_t        state_next;
    logic [size_width-1:0] frame_len;
    logic                  start;

    // Full frame available, or leftover words have waited long enough.
    assign start = (fifo.size >= frame_limit) || flush_due;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            frame_len <= '0;
        end else begin
            state <= state_next;
            if (state == idle && start)
                frame_len <= (fifo.size < frame_limit) ? fifo.size : frame_limit;
        end
    end

    always_comb begin
        state_next       = state;
        fifo.read        = 1'b0;
        ctrl.load_header = 1'b0;
        ctrl.pass_data   = 1'b0;
        ctrl.frame_done  = 1'b0;
        case (state)
            idle: begin
                if (start)
                    state_next = header;
            end
            header: begin
                ctrl.load_header = 1'b1;
                state_next       = data;
            end
            data: begin
                fifo.read      = 1'b1;  // Head word is taken this cycle.
                ctrl.pass_data = 1'b1;
                if (last_word) begin
                    ctrl.frame_done = 1'b1;
                    state_next      = idle;  // At least one idle cycle between frames.
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    assign ctrl.word_count = frame_len;

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        fifo.read |-> !fifo.empty
    ) else $error("FIFO read while empty in state %s", state.name());

endmodule

/* rtl/frame_builder.sv */
// ==============================
// Output register of the readout buffer.
// Forms header words, passes FIFO data, counts frames
// and keeps the sticky overflow flag.
// ==============================
`timescale 1ns/10ps

module frame_builder import readout_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    fifo_if.source                fifo,
    frame_ctrl_if.builder         ctrl,
    output logic [data_width-1:0] out_data,
    output logic                  out_valid,
    output logic                  out_header,
    output logic                  overflow
);

    frame_word_t                word_reg;
    logic [frame_num_width-1:0] frame_num;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_header <= 1'b0;
            overflow   <= 1'b0;
            frame_num  <= '0;
        end else begin
            out_valid  <= ctrl.load_header || ctrl.pass_data;
            out_header <= ctrl.load_header;
            if (fifo.write && fifo.full)
                overflow <= 1'b1;  // Stays set until reset.
            if (ctrl.frame_done)
                frame_num <= frame_num + 1'b1;  // Wraps at 12 bits.
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_header) begin
            word_reg.header.marker    <= header_marker;
            word_reg.header.frame_num <= frame_num;
            word_reg.header.count     <= ctrl.word_count;
        end else if (ctrl.pass_data) begin
            word_reg.raw <= fifo.data_out;  // Raw hit word.
        end
    end

    assign out_data = word_reg.raw;

endmodule

/* rtl/readout_top.sv */
// ==============================
// Detector readout buffer top level.
// Hits in through a write strobe, framed words out
// as valid pulses with no back-pressure.
// ==============================
`timescale 1ns/10ps

module readout_top import readout_pkg::*; #(
    parameter int DEPTH        = 16,
    parameter int FRAME_WORDS  = 4,
    parameter int FLUSH_CYCLES = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hit_write,
    input  logic [data_width-1:0] hit_data,
    output logic [data_width-1:0] out_data,
    output logic                  out_valid,
    output logic                  out_header,
    output logic                  fifo_full,
    output logic                  overflow
);

    fifo_if       fifo_bus ();
    frame_ctrl_if ctrl_bus ();

    logic flush_due;
    logic last_word;

    assign fifo_bus.write   = hit_write;
    assign fifo_bus.data_in = hit_data;
    assign fifo_full        = fifo_bus.full;

    generic_fifo #(
        .DEPTH      (DEPTH),
        .DATA_WIDTH (data_width)
    ) u_fifo (
        .clk   (clk),
        .reset (reset),
        .bus   (fifo_bus)
    );

    frame_timer #(
        .FLUSH_CYCLES (FLUSH_CYCLES),
        .FRAME_WORDS  (FRAME_WORDS)
    ) u_timer (
        .clk        (clk),
        .reset      (reset),
        .write_seen (hit_write),
        .fifo_empty (fifo_bus.empty),
        .ctrl       (ctrl_bus),
        .flush_due  (flush_due),
        .last_word  (last_word)
    );

    readout_fsm #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_fsm (
        .clk       (clk),
        .reset     (reset),
        .fifo      (fifo_bus),
        .ctrl      (ctrl_bus),
        .flush_due (flush_due),
        .last_word (last_word)
    );

    frame_builder u_builder (
        .clk        (clk),
        .reset      (reset),
        .fifo       (fifo_bus),
        .ctrl       (ctrl_bus),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_header (out_header),
        .overflow   (overflow)
    );

endmodule

/* tests/tb_readout.sv */
// ==============================
// Testbench for the readout buffer top level.
// Bursts of hits come from a table, and every output word is
// checked against a queue of the accepted hits.
// ==============================
`timescale 1ns/10ps

module tb_readout;

    localparam int frame_words  = 4;
    localparam int flush_cycles = 8;
    localparam int fifo_depth   = 16;
    localparam int reset_cycles = 4;
    localparam int n_entries    = 8;

    // Burst length, idle cycles after it, overflow level expected after the gap.
    int   burst_len [n_entries] = '{0, 8, 4, 3, 6, 1, 64, 5};
    int   gap_len   [n_entries] = '{20, 3, 14, 20, 24, 16, 40, 24};
    logic ovf_after [n_entries] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    logic        clk = 1'b0;
    logic        reset;
    logic        hit_write;
    logic [31:0] hit_data;
    logic [31:0] out_data;
    logic        out_valid;
    logic        out_header;
    logic        fifo_full;
    logic        overflow;

    logic [31:0] model_q [$];  // Accepted hits not yet read out.
    logic [15:0] lfsr_state;
    logic [11:0] frame_count;
    logic        exp_overflow;
    int          data_left;
    int          flush_frames;
    int          dropped_words;
    int          cycle_count;
    int          timeout_limit;

    readout_top uut (
        .clk        (clk),
        .reset      (reset),
        .hit_write  (hit_write),
        .hit_data   (hit_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_header (out_header),
        .fifo_full  (fifo_full),
        .overflow   (overflow)
    );

    always #4 clk = ~clk;  // 8 ns period.

    task automatic stop_run_failed();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_run_failed();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run_failed();
        end
    endtask

    // Taps of x^16 + x^14 + x^13 + x^11 stepped one bit per call.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic make_hit(output logic [31:0] word);
        word = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word       = {word[30:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_burst(input int n);
        logic [31:0] word;
        repeat (n) begin
            @(posedge clk);
            #1;
            make_hit(word);
            hit_write = 1'b1;
            hit_data  = word;
        end
    endtask

    task automatic drive_gap(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            hit_write = 1'b0;
        end
    endtask

    function automatic int table_cycles();
        int total;
        total = 0;
        for (int i = 0; i < n_entries; i++)
            total += burst_len[i] + gap_len[i];
        return total;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit)
            report_problem("Timeout: the output did not drain within the cycle limit");
    end

    // Outputs and the write strobe are stable at the falling edge.
    always @(negedge clk) begin
        logic [31:0] expected;
        int          hdr_count;
        logic        model_full;
        if (!reset) begin
            check_value("overflow", 32'(overflow), 32'(exp_overflow));
            if (data_left > 0) begin
                if (!out_valid || out_header)
                    report_problem("Data pulses of a frame stopped before the header count");
                if (model_q.size() == 0)
                    report_problem("A data word came out while no hit was queued");
                expected = model_q.pop_front();
                check_value("out_data", out_data, expected);
                data_left--;
            end else if (out_valid) begin
                if (!out_header)
                    report_problem("A data word came out outside a frame");
                hdr_count = int'(out_data[15:0]);
                check_value("header marker", 32'(out_data[31:28]), 32'h0000_000a);
                check_value("header frame number", 32'(out_data[27:16]), 32'(frame_count));
                if (hdr_count == 0 || hdr_count > frame_words)
                    report_problem("Header word count is outside 1 to FRAME_WORDS");
                if (hdr_count < frame_words) begin
                    check_value("header count", 32'(hdr_count), 32'(model_q.size()));
                    flush_frames++;  // Short frames only come from a flush.
                end
                data_left   = hdr_count;
                frame_count = frame_count + 12'd1;
            end
            // Queued words not yet output are the words still in the FIFO.
            model_full = (model_q.size() >= fifo_depth - 1);
            check_value("fifo_full", 32'(fifo_full), 32'(model_full));
            if (hit_write && !model_full)
                model_q.push_back(hit_data);
            if (hit_write && model_full) begin
                exp_overflow = 1'b1;  // Dropped at the next edge.
                dropped_words++;
            end
        end
    end

    initial begin
        reset         = 1'b1;
        hit_write     = 1'b0;
        hit_data      = '0;
        lfsr_state    = 16'd80;
        frame_count   = '0;
        exp_overflow  = 1'b0;
        data_left     = 0;
        flush_frames  = 0;
        dropped_words = 0;
        cycle_count   = 0;
        timeout_limit = table_cycles() + reset_cycles + 20 * flush_cycles + 200;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("overflow", 32'(overflow), 32'h0);

        for (int i = 0; i < n_entries; i++) begin
            drive_burst(burst_len[i]);
            drive_gap(gap_len[i]);
            check_value("overflow", 32'(overflow), 32'(ovf_after[i]));
        end

        // Leftover words leave in a last flushed frame.
        while (model_q.size() != 0 || data_left != 0)
            @(posedge clk);
        drive_gap(flush_cycles + 10);

        if (flush_frames == 0)
            report_problem("No flushed frame with a short count was seen");
        else if (dropped_words == 0)
            report_problem("The long burst never filled the FIFO");
        else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* project.f */
rtl/readout_pkg.sv
rtl/fifo_if.sv
rtl/generic_fifo.sv
rtl/frame_timer.sv
rtl/readout_fsm.sv
rtl/frame_builder.sv
rtl/readout_top.sv
tests/tb_readout.sv

/* Makefile */
# Verilator build and run of the readout buffer testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_readout
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output.
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
